//--- source/serial_pkg.sv
/*
 * shared definitions for the 3-wire serial master
 *   word width and bit order
 *   idle levels of the serial clock and data lines
 *   serial clock divider ratio and queue depth
 *   word type and transmitter state enum
 */

`default_nettype none

package serial_pkg;

	// ------------------------------------------------------------
	// serial word format
	// ------------------------------------------------------------
	// bits per serial word
	localparam int word_bits = 8;
	// 1: lsb goes out first, 0: msb goes out first
	localparam bit lowbit_first = 1'b1;

	// ------------------------------------------------------------
	// line levels and timing
	// ------------------------------------------------------------
	// sck rests high, data launched on fall, sampled on rise
	localparam bit sck_idle = 1'b1;
	localparam bit sdo_idle = 1'b1;
	// serial_clk cycles per sck half period
	localparam int sck_half = 4;

	// entries per word queue
	localparam int fifo_depth = 4;

	// one serial word
	typedef logic [word_bits-1:0] word_t;

	// transmitter states
	typedef enum logic [0:0] {tx_idle, tx_shift} tx_state_e;

endpackage

`default_nettype wire

//--- source/serial_word_fifo.sv
/*
 * synchronous word queue
 *   circular buffer with read and write pointers
 *   occupancy count with empty and full flags
 */

`default_nettype none
`timescale 1ns/1ps

module serial_word_fifo #(
	parameter int depth = serial_pkg::fifo_depth
) (
	input  wire                serial_clk,
	input  wire                in_rst,
	input  wire                push,
	input  serial_pkg::word_t  push_data,
	input  wire                pop,
	output serial_pkg::word_t  head,
	output logic               empty,
	output logic               full
);

	// at least one pointer bit even for a single entry
	typedef logic [$clog2(depth > 1 ? depth : 2)-1:0] ptr_t;
	typedef logic [$clog2(depth + 1)-1:0] count_t;

	serial_pkg::word_t mem [depth];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	count_t count;
	logic do_push;
	logic do_pop;

	// full refuses a push, empty refuses a pop
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign empty = count == '0;
	assign full = int'(count) == depth;
	// oldest entry, valid while not empty
	assign head = mem[rd_ptr];

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap at depth, not at a power of two
			if (do_push)
				wr_ptr <= int'(wr_ptr) == depth - 1 ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= int'(rd_ptr) == depth - 1 ? '0 : rd_ptr + 1'b1;
			// push with pop leaves the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// storage
	always_ff @(posedge serial_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	a_count_range: assert property (@(posedge serial_clk) disable iff (in_rst)
		int'(count) <= depth);

endmodule

`default_nettype wire

//--- source/serial_clkgen.sv
/*
 * serial clock generator
 *   divides serial_clk into a gated sck
 *   one-cycle fall and rise strobes aligned with the sck toggles
 */

`default_nettype none
`timescale 1ns/1ps

module serial_clkgen (
	input  wire  serial_clk,
	input  wire  in_rst,
	// keep sck toggling while high
	input  wire  run,
	output logic sck,
	output logic fall_stb,
	output logic rise_stb
);

	typedef logic [$clog2(serial_pkg::sck_half)-1:0] half_cnt_t;

	// cycles spent in the current half period
	half_cnt_t half_cnt;
	logic half_end;

	assign half_end = int'(half_cnt) == serial_pkg::sck_half - 1;

	// ------------------------------------------------------------
	// half-period counter and sck phase
	// ------------------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			sck <= serial_pkg::sck_idle;
			half_cnt <= '0;
			fall_stb <= 1'b0;
			rise_stb <= 1'b0;
		end else begin
			// strobes are single cycle
			fall_stb <= 1'b0;
			rise_stb <= 1'b0;
			if (!run && sck == serial_pkg::sck_idle) begin
				// parked at idle level, restart a full half on next run
				half_cnt <= '0;
			end else if (half_end) begin
				half_cnt <= '0;
				sck <= ~sck;
				// strobe names follow the new sck level
				fall_stb <= sck;
				rise_stb <= ~sck;
			end else begin
				// an active half always completes, even if run dropped
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// sck cannot go both ways in one cycle
	a_one_edge: assert property (@(posedge serial_clk) disable iff (in_rst)
		!(fall_stb && rise_stb));

endmodule

`default_nettype wire

//--- source/serial_duplex.sv
/*
 * duplex serial core
 *   transmit FSM with bit counter and word register
 *   receive assembler with its own bit counter
 *   word done strobes for both directions
 */

`default_nettype none
`timescale 1ns/1ps

module serial_duplex (
	input  wire                serial_clk,
	input  wire                in_rst,
	// edge strobes from the clock generator
	input  wire                fall_stb,
	input  wire                rise_stb,
	// transmit queue side
	input  serial_pkg::word_t  tx_word,
	input  wire                tx_avail,
	output logic               tx_load,
	output logic               tx_active,
	output logic               tx_word_done,
	output logic               sdo,
	// receive side
	input  wire                rx_enable,
	input  wire                sdi,
	output serial_pkg::word_t  rx_word,
	output logic               rx_valid
);

	typedef logic [$clog2(serial_pkg::word_bits)-1:0] bit_idx_t;

	// map a bit counter onto a word index for the configured order
	function automatic bit_idx_t bit_pos(input bit_idx_t cnt);
		if (serial_pkg::lowbit_first)
			return cnt;
		else
			return bit_idx_t'(serial_pkg::word_bits - 1 - int'(cnt));
	endfunction

	// ------------------------------------------------------------
	// transmit
	// ------------------------------------------------------------
	serial_pkg::tx_state_e tx_state;
	bit_idx_t tx_cnt;
	serial_pkg::word_t tx_shreg;
	logic tx_last;
	// fall strobe where a new word may start
	logic tx_reload;

	assign tx_last = int'(tx_cnt) == serial_pkg::word_bits - 1;
	assign tx_reload = fall_stb && (tx_state == serial_pkg::tx_idle || tx_last);

	// pop the queue in the same cycle the word is captured
	assign tx_load = tx_reload && tx_avail;
	assign tx_active = tx_state == serial_pkg::tx_shift;
	// fall strobe closing the last bit
	assign tx_word_done = fall_stb && tx_state == serial_pkg::tx_shift && tx_last;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			tx_state <= serial_pkg::tx_idle;
			tx_cnt <= '0;
			sdo <= serial_pkg::sdo_idle;
		end else if (tx_reload) begin
			tx_cnt <= '0;
			if (tx_avail) begin
				// next word follows without a gap
				tx_state <= serial_pkg::tx_shift;
				sdo <= tx_word[bit_pos('0)];
			end else begin
				tx_state <= serial_pkg::tx_idle;
				sdo <= serial_pkg::sdo_idle;
			end
		end else if (fall_stb) begin
			// mid word, launch the next bit
			tx_cnt <= tx_cnt + 1'b1;
			sdo <= tx_shreg[bit_pos(tx_cnt + 1'b1)];
		end
	end

	// word being shifted out
	always_ff @(posedge serial_clk) begin
		if (tx_load)
			tx_shreg <= tx_word;
	end

	// ------------------------------------------------------------
	// receive
	// ------------------------------------------------------------
	bit_idx_t rx_cnt;
	serial_pkg::word_t rx_shreg;
	logic rx_last;
	logic rx_sample;

	assign rx_last = int'(rx_cnt) == serial_pkg::word_bits - 1;
	assign rx_sample = rx_enable && rise_stb;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			rx_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!rx_enable) begin
				// drop any partial word
				rx_cnt <= '0;
			end else if (rise_stb) begin
				if (rx_last) begin
					rx_cnt <= '0;
					// word complete one cycle after the last sample
					rx_valid <= 1'b1;
				end else begin
					rx_cnt <= rx_cnt + 1'b1;
				end
			end
		end
	end

	// sdi into its slot of the word
	always_ff @(posedge serial_clk) begin
		if (rx_sample)
			rx_shreg[bit_pos(rx_cnt)] <= sdi;
	end

	assign rx_word = rx_shreg;

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// a load pops the queue, so it needs a word there
	a_load_avail: assert property (@(posedge serial_clk) disable iff (in_rst)
		tx_load |-> tx_avail);

	// line rests whenever the transmitter is idle
	a_idle_sdo: assert property (@(posedge serial_clk) disable iff (in_rst)
		tx_state == serial_pkg::tx_idle |-> sdo == serial_pkg::sdo_idle);

endmodule

`default_nettype wire

//--- source/serial_master.sv
/*
 * 3-wire serial master top level
 *   transmit and receive word queues
 *   sck generator and duplex core
 *   receive overflow flag
 */

`default_nettype none
`timescale 1ns/1ps

module serial_master (
	input  wire                serial_clk,
	input  wire                in_rst,
	// host transmit side
	input  serial_pkg::word_t  tx_data,
	input  wire                tx_push,
	output logic               tx_full,
	// host receive side
	input  wire                rx_enable,
	output serial_pkg::word_t  rx_data,
	input  wire                rx_pop,
	output logic               rx_empty,
	output logic               rx_overflow,
	// status pulses
	output logic               tx_word_done,
	output logic               rx_word_done,
	// chip side
	output logic               sck,
	output logic               sdo,
	input  wire                sdi
);

	serial_pkg::word_t tx_word;
	serial_pkg::word_t rx_word;
	logic tx_empty;
	logic tx_load;
	logic tx_active;
	logic rx_valid;
	logic rx_full;
	logic run;
	logic fall_stb;
	logic rise_stb;

	// ------------------------------------------------------------
	// clock enable and status
	// ------------------------------------------------------------
	// sck runs while words wait, one is on the wire, or rx is on
	assign run = !tx_empty || tx_active || rx_enable;

	// finished word with nowhere to go, the queue drops it
	assign rx_overflow = rx_valid && rx_full;
	assign rx_word_done = rx_valid;

	serial_word_fifo #(
		.depth(serial_pkg::fifo_depth)
	) u_tx_fifo (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.push(tx_push),
		.push_data(tx_data),
		.pop(tx_load),
		.head(tx_word),
		.empty(tx_empty),
		.full(tx_full)
	);

	serial_clkgen u_clkgen (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.run(run),
		.sck(sck),
		.fall_stb(fall_stb),
		.rise_stb(rise_stb)
	);

	serial_duplex u_duplex (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.fall_stb(fall_stb),
		.rise_stb(rise_stb),
		.tx_word(tx_word),
		.tx_avail(!tx_empty),
		.tx_load(tx_load),
		.tx_active(tx_active),
		.tx_word_done(tx_word_done),
		.sdo(sdo),
		.rx_enable(rx_enable),
		.sdi(sdi),
		.rx_word(rx_word),
		.rx_valid(rx_valid)
	);

	serial_word_fifo #(
		.depth(serial_pkg::fifo_depth)
	) u_rx_fifo (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.push(rx_valid),
		.push_data(rx_word),
		.pop(rx_pop),
		.head(rx_data),
		.empty(rx_empty),
		.full(rx_full)
	);

endmodule

`default_nettype wire

//--- test/serial_master_tb.sv
/*
 * testbench for the 3-wire serial master
 *   clock, reset and cycle timeout
 *   chip model that decodes sdo and drives sdi
 *   compare tasks and directed tests
 */

`default_nettype none
`timescale 1ns/1ps

module serial_master_tb;

	typedef logic [$clog2(serial_pkg::word_bits)-1:0] bit_idx_t;

	logic serial_clk;
	logic in_rst;
	serial_pkg::word_t tx_data;
	logic tx_push;
	logic tx_full;
	logic rx_enable;
	serial_pkg::word_t rx_data;
	logic rx_pop;
	logic rx_empty;
	logic rx_overflow;
	logic tx_word_done;
	logic rx_word_done;
	logic sck;
	logic sdo;
	wire sdi;

	// chip model state
	logic loopback = 1'b0;
	logic sdi_chip = 1'b1;
	logic decode_on = 1'b0;
	serial_pkg::word_t chip_words [16];
	serial_pkg::word_t chip_word;
	serial_pkg::word_t dec_word;
	int chip_wr = 0;
	int chip_rd = 0;
	int chip_cnt = 0;
	int dec_cnt = 0;
	// words decoded from sdo
	serial_pkg::word_t dec_q [$];
	int txd_cnt = 0;
	int ovf_cnt = 0;
	int refused_cnt = 0;
	int cycle_cnt = 0;
	logic [31:0] rng = 32'h5b22_66bb;

	serial_master u_serial_master (
		.serial_clk(serial_clk),
		.in_rst(in_rst),
		.tx_data(tx_data),
		.tx_push(tx_push),
		.tx_full(tx_full),
		.rx_enable(rx_enable),
		.rx_data(rx_data),
		.rx_pop(rx_pop),
		.rx_empty(rx_empty),
		.rx_overflow(rx_overflow),
		.tx_word_done(tx_word_done),
		.rx_word_done(rx_word_done),
		.sck(sck),
		.sdo(sdo),
		.sdi(sdi)
	);

	// loopback ties sdi to sdo
	assign sdi = loopback ? sdo : sdi_chip;

	initial begin
		serial_clk = 1'b0;
		forever #10 serial_clk = ~serial_clk;
	end

	// wire position of the n-th bit on the line
	function automatic bit_idx_t bit_index(input int n);
		if (serial_pkg::lowbit_first)
			return bit_idx_t'(n);
		else
			return bit_idx_t'(serial_pkg::word_bits - 1 - n);
	endfunction

	// lcg, upper bits give the word
	function automatic serial_pkg::word_t rand_word();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return serial_pkg::word_t'(rng >> 16);
	endfunction

	// ------------------------------------------------------------
	// chip model
	// ------------------------------------------------------------
	// sdo sampled on rising sck while decoding is on
	always @(posedge sck or negedge decode_on) begin
		if (!decode_on) begin
			dec_cnt = 0;
		end else begin
			dec_word[bit_index(dec_cnt)] = sdo;
			dec_cnt = dec_cnt + 1;
			if (dec_cnt == serial_pkg::word_bits) begin
				dec_q.push_back(dec_word);
				dec_cnt = 0;
			end
		end
	end

	// queued words go out on sdi after each falling sck, back to back
	always @(negedge sck) begin
		if (chip_cnt == 0 && chip_rd < chip_wr) begin
			chip_word = chip_words[chip_rd];
			chip_rd = chip_rd + 1;
			chip_cnt = serial_pkg::word_bits;
		end
		if (chip_cnt > 0) begin
			sdi_chip <= chip_word[bit_index(serial_pkg::word_bits - chip_cnt)];
			chip_cnt = chip_cnt - 1;
		end else begin
			sdi_chip <= 1'b1;
		end
	end

	// host side monitor
	always @(posedge serial_clk) begin
		if (tx_push && tx_full)
			refused_cnt = refused_cnt + 1;
		if (tx_word_done)
			txd_cnt = txd_cnt + 1;
		if (rx_overflow)
			ovf_cnt = ovf_cnt + 1;
	end

	// 6 tests of up to 6 words, 2 halves per bit, plus margin
	always @(posedge serial_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > 6 * 6 * serial_pkg::word_bits * 2 * serial_pkg::sck_half + 1000) begin
			$display("Simulation failed");
			$fatal(1, "timeout: tests did not finish");
		end
	end

	// ------------------------------------------------------------
	// compare and drive helpers
	// ------------------------------------------------------------
	task automatic compare_word(input string name, input serial_pkg::word_t got,
			input serial_pkg::word_t exp);
		if (got !== exp) begin
			$display("Fail: %s = %h, expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "word mismatch on %s", name);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail: %s = %h, expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "bit mismatch on %s", name);
		end
	endtask

	task automatic apply_reset();
		repeat (2) @(posedge serial_clk);
		in_rst <= 1'b0;
	endtask

	task automatic push_word(input serial_pkg::word_t w);
		@(posedge serial_clk);
		tx_data <= w;
		tx_push <= 1'b1;
	endtask

	task automatic end_push();
		@(posedge serial_clk);
		tx_push <= 1'b0;
	endtask

	// long enough for a low half to finish and sck to park high
	task automatic settle_idle();
		repeat (4 * serial_pkg::sck_half) @(posedge serial_clk);
	endtask

	task automatic wait_rx_done();
		@(posedge serial_clk);
		while (!rx_word_done)
			@(posedge serial_clk);
	endtask

	task automatic pop_and_check(input serial_pkg::word_t exp);
		@(posedge serial_clk);
		compare_word("rx_data", rx_data, exp);
		rx_pop <= 1'b1;
		@(posedge serial_clk);
		rx_pop <= 1'b0;
	endtask

	task automatic receive_and_check(input serial_pkg::word_t exp);
		wait_rx_done();
		pop_and_check(exp);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic check_idle();
		@(posedge serial_clk);
		compare_bit("sdo", sdo, serial_pkg::sdo_idle);
		compare_bit("rx_empty", rx_empty, 1'b1);
		compare_bit("tx_full", tx_full, 1'b0);
		compare_bit("tx_word_done", tx_word_done, 1'b0);
		compare_bit("rx_word_done", rx_word_done, 1'b0);
		compare_bit("rx_overflow", rx_overflow, 1'b0);
		// sck parked with nothing to do
		repeat (50) begin
			compare_bit("sck", sck, serial_pkg::sck_idle);
			@(posedge serial_clk);
		end
	endtask

	// push n words from a stopped sck, n_accept of them fit in the queue
	task automatic transmit_burst(input int n, input int n_accept);
		serial_pkg::word_t pushed [$];
		int dec_base;
		int done_base;
		int refused_base;
		dec_base = dec_q.size();
		done_base = txd_cnt;
		refused_base = refused_cnt;
		decode_on = 1'b1;
		for (int i = 0; i < n; i++) begin
			pushed.push_back(rand_word());
			push_word(pushed[i]);
		end
		end_push();
		while (txd_cnt - done_base < n_accept)
			@(posedge serial_clk);
		settle_idle();
		decode_on = 1'b0;
		// queue fills before the first pop, extra pushes meet tx_full
		compare_word("refused pushes", serial_pkg::word_t'(refused_cnt - refused_base),
			serial_pkg::word_t'(n - n_accept));
		compare_word("tx_word_done count", serial_pkg::word_t'(txd_cnt - done_base),
			serial_pkg::word_t'(n_accept));
		compare_word("decoded words", serial_pkg::word_t'(dec_q.size() - dec_base),
			serial_pkg::word_t'(n_accept));
		// oldest pushes go out in order
		for (int i = 0; i < n_accept; i++)
			compare_word("sdo word", dec_q[dec_base + i], pushed[i]);
		compare_bit("sdo", sdo, serial_pkg::sdo_idle);
		compare_bit("sck", sck, serial_pkg::sck_idle);
	endtask

	task automatic receive_burst(input int n);
		int base;
		base = chip_wr;
		for (int i = 0; i < n; i++) begin
			chip_words[chip_wr] = rand_word();
			chip_wr = chip_wr + 1;
		end
		@(posedge serial_clk);
		rx_enable <= 1'b1;
		for (int i = 0; i < n; i++)
			receive_and_check(chip_words[base + i]);
		rx_enable <= 1'b0;
		settle_idle();
	endtask

	task automatic loopback_duplex();
		serial_pkg::word_t words [serial_pkg::fifo_depth];
		for (int i = 0; i < serial_pkg::fifo_depth; i++)
			words[i] = rand_word();
		loopback = 1'b1;
		@(posedge serial_clk);
		rx_enable <= 1'b1;
		for (int i = 0; i < serial_pkg::fifo_depth; i++)
			push_word(words[i]);
		end_push();
		for (int i = 0; i < serial_pkg::fifo_depth; i++)
			receive_and_check(words[i]);
		rx_enable <= 1'b0;
		settle_idle();
		loopback = 1'b0;
	endtask

	// one word more than the receive queue holds, no pops
	task automatic overflow_queue();
		int base;
		int ovf_base;
		base = chip_wr;
		ovf_base = ovf_cnt;
		for (int i = 0; i <= serial_pkg::fifo_depth; i++) begin
			chip_words[chip_wr] = rand_word();
			chip_wr = chip_wr + 1;
		end
		@(posedge serial_clk);
		rx_enable <= 1'b1;
		repeat (serial_pkg::fifo_depth + 1)
			wait_rx_done();
		rx_enable <= 1'b0;
		settle_idle();
		compare_word("rx_overflow count", serial_pkg::word_t'(ovf_cnt - ovf_base),
			serial_pkg::word_t'(1));
		for (int i = 0; i < serial_pkg::fifo_depth; i++)
			pop_and_check(chip_words[base + i]);
		@(posedge serial_clk);
		compare_bit("rx_empty", rx_empty, 1'b1);
	endtask

	initial begin
		in_rst = 1'b1;
		tx_data = '0;
		tx_push = 1'b0;
		rx_enable = 1'b0;
		rx_pop = 1'b0;
		apply_reset();
		check_idle();
		transmit_burst(3, 3);
		receive_burst(2);
		loopback_duplex();
		transmit_burst(serial_pkg::fifo_depth + 1, serial_pkg::fifo_depth);
		overflow_queue();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
source/serial_pkg.sv
source/serial_word_fifo.sv
source/serial_clkgen.sv
source/serial_duplex.sv
source/serial_master.sv
test/serial_master_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the serial master testbench with Verilator
# the exit status is the simulator's, nonzero after a $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module serial_master_tb -f src.f \
	-Mdir obj_dir -o serial_master_sim \
	&& ./obj_dir/serial_master_sim \
	|| { echo "verilator build or run returned an error"; exit 1; }
